// ==== files.f ====
+incdir+design
+incdir+bench
design/ee_types_pkg.sv
design/ee_cmd_pkg.sv
design/ee_wr_if.sv
design/ee_serial_front.sv
design/ee_write_engine.sv
design/ee_serial_eeprom.sv
bench/tb_ee_serial_eeprom.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the serial EEPROM testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_ee_serial_eeprom \
	-o sim_tb && output=$(./obj_dir/sim_tb)
echo "$output"
echo "$output" | grep -q "Finished with no errors" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== bench/tb_ee_model.svh ====
// EEPROM reference model
`ifndef TB_EE_MODEL_SVH
`define TB_EE_MODEL_SVH

logic [15:0] model_mem [64];	// Unknown until the first ERAL
logic model_en;					// Mirrors the write-enable latch

// Op codes for the model, plain numbers
localparam int M_WRITE = 0;
localparam int M_ERASE = 1;
localparam int M_WRAL = 2;
localparam int M_ERAL = 3;
localparam int M_EWEN = 4;
localparam int M_EWDS = 5;

// Applies one finished instruction to the model
function automatic void model_apply(int op, logic [5:0] addr, logic [15:0] data);
	case (op)
		M_EWEN: model_en = 1'b1;
		M_EWDS: model_en = 1'b0;
		M_WRITE: if (model_en) model_mem[addr] = data;
		M_ERASE: if (model_en) model_mem[addr] = 16'hffff;	// Erased word is all ones
		M_WRAL: begin
			if (model_en)
				for (int i = 0; i < 64; i++)
					model_mem[i] = data;
		end
		M_ERAL: begin
			if (model_en)
				for (int i = 0; i < 64; i++)
					model_mem[i] = 16'hffff;
		end
		default: ;
	endcase
endfunction

// Word a READ of addr should shift out
function automatic logic [15:0] expected_word(logic [5:0] addr);
	return model_mem[addr];
endfunction

`endif

// ==== bench/tb_ee_serial_eeprom.sv ====
// Serial EEPROM testbench
`timescale 1ns/1ps

module tb_ee_serial_eeprom;
	logic sys_clk;
	logic xresetl;
	logic cs_i;
	logic sk_i;
	logic di_i;
	logic do_o;
	int errors;
	int tests;
	logic [31:0] rng;		// Xorshift state
	logic [15:0] chk_got;
	logic [15:0] chk_exp;
	string chk_what;
	event check_ev;

	`include "tb_ee_model.svh"

	ee_serial_eeprom dut0 (
		.sys_clk(sys_clk),
		.xresetl(xresetl),
		.cs_i(cs_i),
		.sk_i(sk_i),
		.di_i(di_i),
		.do_o(do_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;	// 40 ns period
	end

	// Comparing process
	always @(check_ev) begin
		if (chk_got !== chk_exp) begin
			errors++;
			$display("Error at %0d ns: %s got %h expected %h", $time, chk_what, chk_got, chk_exp);
		end
	end

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic tick();
		@(posedge sys_clk);
		#2;	// Drive just after the edge
	endtask

	task automatic check(logic [15:0] got, logic [15:0] exp, string what);
		chk_got = got;
		chk_exp = exp;
		chk_what = what;
		->check_ev;
	endtask

	// One serial bit, do_o sampled in last low cycle
	task automatic send_bit(logic b, output logic s);
		di_i = b;
		sk_i = 1'b0;
		tick();
		tick();
		tick();
		s = do_o;
		sk_i = 1'b1;
		tick();
		tick();
		tick();
	endtask

	task automatic send_bits(logic [15:0] v, int n);
		logic s;
		for (int i = n - 1; i >= 0; i--)
			send_bit(v[i], s);
	endtask

	task automatic deselect();
		cs_i = 1'b0;
		sk_i = 1'b0;
		tick();
		tick();
	endtask

	// Start bit, opcode, address
	task automatic send_instr(logic [1:0] op, logic [5:0] addr);
		cs_i = 1'b1;
		tick();
		send_bits({7'b0, 1'b1, op, addr}, 9);
	endtask

	task automatic wait_ready();
		int n;
		n = 0;
		sk_i = 1'b0;
		while (do_o !== 1'b1 && n < 300) begin
			tick();
			n++;
		end
		if (do_o !== 1'b1) begin
			errors++;
			$display("Timeout: do_o never returned ready after a write");
		end
	endtask

	// Expects busy right after the command, then ready
	task automatic finish_write(string what);
		check({15'b0, do_o}, 16'h0, {what, " busy on do_o"});
		wait_ready();
		deselect();
	endtask

	task automatic read_check(logic [5:0] addr, int extra);
		logic s;
		logic [15:0] w;
		send_instr(2'b10, addr);
		send_bit(1'b0, s);
		check({15'b0, s}, 16'h0, "read dummy bit");
		for (int i = 15; i >= 0; i--) begin
			send_bit(1'b0, s);
			w[i] = s;
		end
		check(w, expected_word(addr), $sformatf("read addr %0d", addr));
		for (int i = 0; i < extra; i++) begin
			send_bit(1'b0, s);
			check({15'b0, s}, 16'h0, "zero after last bit");
		end
		deselect();
	endtask

	task automatic write_word(logic [5:0] addr, logic [15:0] data);
		send_instr(2'b01, addr);
		send_bits(data, 16);
		model_apply(M_WRITE, addr, data);
		finish_write("WRITE");
	endtask

	task automatic ext_cmd(logic [1:0] ext);
		send_instr(2'b00, {ext, 4'b0});
		deselect();
	endtask

	initial begin
		logic [5:0] a;
		logic [5:0] addrs [12];
		logic [15:0] d;
		errors = 0;
		tests = 0;
		rng = 32'd38;
		model_en = 1'b0;
		for (int i = 0; i < 64; i++)
			model_mem[i] = 'x;
		xresetl = 1'b0;
		cs_i = 1'b0;
		sk_i = 1'b0;
		di_i = 1'b0;
		repeat (8) tick();	// Reset 8 cycles
		xresetl = 1'b1;
		tick();

		// Test 1 idle levels
		check({15'b0, do_o}, 16'h1, "do_o deselected");
		cs_i = 1'b1;
		repeat (5) tick();
		check({15'b0, do_o}, 16'h1, "do_o selected idle");
		deselect();
		tests++;
		$display("Test 1 idle do_o done, errors %0d", errors);

		// Test 2 EWEN then ERAL
		ext_cmd(2'b11);
		model_apply(M_EWEN, 6'd0, 16'h0);
		send_instr(2'b00, 6'b100000);
		model_apply(M_ERAL, 6'd0, 16'h0);
		finish_write("ERAL");
		for (int i = 0; i < 8; i++)
			read_check(6'(i * 9), 0);
		tests++;
		$display("Test 2 ERAL done, errors %0d", errors);

		// Test 3 random writes then reads
		for (int i = 0; i < 12; i++) begin
			rng = xorshift(rng);
			addrs[i] = rng[5:0];
			write_word(addrs[i], rng[31:16]);
		end
		for (int i = 0; i < 12; i++)
			read_check(addrs[i], 0);
		tests++;
		$display("Test 3 WRITE/READ done, errors %0d", errors);

		// Test 4 write protection
		a = addrs[0];
		ext_cmd(2'b00);
		model_apply(M_EWDS, 6'd0, 16'h0);
		write_word(a, 16'h1234);
		send_instr(2'b11, a);
		model_apply(M_ERASE, a, 16'h0);
		finish_write("ERASE");
		read_check(a, 0);
		ext_cmd(2'b11);
		model_apply(M_EWEN, 6'd0, 16'h0);
		write_word(a - 6'd1, 16'ha5a5);	// Known neighbor below
		write_word(a + 6'd1, 16'h5a5a);	// Known neighbor value
		send_instr(2'b11, a);
		model_apply(M_ERASE, a, 16'h0);
		finish_write("ERASE");
		read_check(a - 6'd1, 0);
		read_check(a, 0);
		read_check(a + 6'd1, 0);
		tests++;
		$display("Test 4 EWDS/ERASE done, errors %0d", errors);

		// Test 5 WRAL
		rng = xorshift(rng);
		d = rng[15:0];
		send_instr(2'b00, 6'b010000);
		send_bits(d, 16);
		model_apply(M_WRAL, 6'd0, d);
		finish_write("WRAL");
		for (int i = 0; i < 64; i++)
			read_check(6'(i), 0);
		read_check(6'd17, 6);
		tests++;
		$display("Test 5 WRAL done, errors %0d", errors);

		// Test 6 deselect mid data
		a = 6'd42;
		send_instr(2'b01, a);
		send_bits(16'h00c3, 8);
		deselect();
		read_check(a, 0);
		tests++;
		$display("Test 6 aborted WRITE done, errors %0d", errors);

		$display("Tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== design/ee_serial_eeprom.sv ====
// 93C46-style serial EEPROM top
`timescale 1ns/1ps
`include "ee_macros.svh"

module ee_serial_eeprom (
	input logic sys_clk,
	input logic xresetl,	// Sync, active low
	input logic cs_i,		// Chip select
	input logic sk_i,		// Serial clock
	input logic di_i,		// Serial data in
	output logic do_o		// Serial data out, ready/busy
);

	ee_wr_if wr_if0();

	// Instruction decode and serial I/O
	ee_serial_front front0 (
		.sys_clk(sys_clk),
		.xresetl(xresetl),
		.cs_i(cs_i),
		.sk_i(sk_i),
		.di_i(di_i),
		.do_o(do_o),
		.wr(wr_if0.front)
	);

	// Array writes and storage
	ee_write_engine engine0 (
		.sys_clk(sys_clk),
		.xresetl(xresetl),
		.wr(wr_if0.engine)
	);

endmodule

// ==== design/ee_write_engine.sv ====
// EEPROM write sequencer and array
`timescale 1ns/1ps
`include "ee_macros.svh"

module ee_write_engine (
	input logic sys_clk,
	input logic xresetl,
	ee_wr_if.engine wr
);
	import ee_types_pkg::*;
	import ee_cmd_pkg::*;

	ee_wr_state_e state;
	ee_word_t mem [`EE_DEPTH];	// 64 x 16 storage
	ee_addr_t addr_q;			// Current write address
	ee_word_t data_q;			// Word being stored
	logic loop_q;				// Walk every address
	logic last_addr;
	logic job_take;

	assign job_take = (state == WS_IDLE) && wr.wr_start;
	assign last_addr = (addr_q == ee_addr_t'(`EE_DEPTH - 1));

	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			state <= WS_IDLE;
			loop_q <= 1'b0;
		end else begin
			case (state)
				WS_IDLE: begin
					if (wr.wr_start) begin
						loop_q <= wr.wr_all;
						state <= WS_BEGIN;
					end
				end
				WS_BEGIN: state <= WS_WRITE;
				WS_WRITE: state <= WS_LOOP;
				WS_LOOP: begin
					// Single word, or all words done
					if (!loop_q || last_addr)
						state <= WS_END;
					else
						state <= WS_WRITE;
				end
				default: state <= WS_IDLE;	// End cycle
			endcase
		end
	end

	// Job payload and address walk
	always_ff @(posedge sys_clk) begin
		if (job_take) begin
			addr_q <= wr.wr_all ? '0 : wr.wr_addr;
			data_q <= wr.wr_erase ? `EE_ERASED : wr.wr_data;
		end else if (state == WS_LOOP && loop_q && !last_addr) begin
			addr_q <= addr_q + ee_addr_t'(1);
		end
	end

	// Stores only with the enable latch set, sequence runs regardless
	always_ff @(posedge sys_clk) begin
		if (state == WS_WRITE && wr.wr_enable)
			mem[addr_q] <= data_q;
	end

	assign wr.busy = (state != WS_IDLE);
	assign wr.rd_data = mem[wr.rd_addr];

endmodule

// ==== design/ee_serial_front.sv ====
// Three-wire serial front end
`timescale 1ns/1ps
`include "ee_macros.svh"

module ee_serial_front (
	input logic sys_clk,
	input logic xresetl,
	input logic cs_i,
	input logic sk_i,
	input logic di_i,
	output logic do_o,
	ee_wr_if.front wr
);
	import ee_types_pkg::*;
	import ee_cmd_pkg::*;

	ee_front_state_e state;
	logic sk_q;			// Serial clock, one sample behind
	logic sk_rise;
	ee_ir_t ir;			// Instruction shift register
	ee_ir_t ir_next;	// With the current DI bit appended
	ee_op_e op;
	ee_ext_e ext;
	ee_bitcnt_t cnt;	// Data bits received
	ee_word_t dr;		// Write data in, read data out
	logic dout_q;		// Read bit on DO
	logic wr_start_q;
	logic wr_all_q;
	logic wr_erase_q;
	logic wr_enable_q;	// EWEN/EWDS latch

	assign sk_rise = sk_i & ~sk_q;
	assign ir_next = {ir[`EE_IR_W-2:0], di_i};
	assign op = ee_op_e'(ir_next[`EE_IR_W-2 -: 2]);		// Bits 7:6
	assign ext = ee_ext_e'(ir_next[`EE_ADDR_W-1 -: 2]);	// Bits 5:4

	// Edge detect sampler
	always_ff @(posedge sys_clk) begin
		sk_q <= sk_i;
	end

	always_ff @(posedge sys_clk) begin
		if (!xresetl) begin
			state <= FS_IDLE;
			ir <= '0;
			cnt <= '0;
			dr <= '0;
			dout_q <= 1'b1;
			wr_start_q <= 1'b0;
			wr_all_q <= 1'b0;
			wr_erase_q <= 1'b0;
			wr_enable_q <= 1'b0;
		end else begin
			wr_start_q <= 1'b0;	// Pulse only
			if (!cs_i) begin
				// Deselect drops any instruction in progress
				state <= FS_IDLE;
				ir <= '0;
				cnt <= '0;
				dr <= '0;
				dout_q <= 1'b1;
			end else if (sk_rise) begin
				case (state)
					FS_IDLE: begin
						// Full IR or busy engine, edges are ignored
						if (!ir[`EE_IR_W-1] && !wr.busy) begin
							ir <= ir_next;
							if (ir[`EE_IR_W-2]) begin	// Start bit reaches top
								case (op)
									OP_READ: begin
										dr <= wr.rd_data;
										dout_q <= 1'b0;	// Dummy bit
										state <= FS_READ;
									end
									OP_WRITE: begin
										wr_all_q <= 1'b0;
										wr_erase_q <= 1'b0;
										state <= FS_DATA;
									end
									OP_ERASE: begin
										wr_all_q <= 1'b0;
										wr_erase_q <= 1'b1;
										wr_start_q <= 1'b1;
									end
									default: begin
										case (ext)
											EXT_EWEN: wr_enable_q <= 1'b1;
											EXT_EWDS: wr_enable_q <= 1'b0;
											EXT_ERAL: begin
												wr_all_q <= 1'b1;
												wr_erase_q <= 1'b1;
												wr_start_q <= 1'b1;
											end
											default: begin	// WRAL
												wr_all_q <= 1'b1;
												wr_erase_q <= 1'b0;
												state <= FS_DATA;
											end
										endcase
									end
								endcase
							end
						end
					end
					FS_DATA: begin
						dr <= {dr[`EE_WORD_W-2:0], di_i};	// MSB first
						cnt <= cnt + ee_bitcnt_t'(1);
						if (cnt == '1) begin	// Sixteenth bit
							wr_start_q <= 1'b1;
							state <= FS_IDLE;	// IR stays full until deselect
						end
					end
					default: begin
						// Read out, zeros follow the last bit
						dout_q <= dr[`EE_WORD_W-1];
						dr <= {dr[`EE_WORD_W-2:0], 1'b0};
					end
				endcase
			end
		end
	end

	assign wr.wr_start = wr_start_q;
	assign wr.wr_all = wr_all_q;
	assign wr.wr_erase = wr_erase_q;
	assign wr.wr_addr = ir[`EE_ADDR_W-1:0];
	assign wr.wr_data = dr;
	assign wr.wr_enable = wr_enable_q;
	assign wr.rd_addr = ir_next[`EE_ADDR_W-1:0];	// Address as the ninth bit lands

	// Read bit, else ready/busy status, high when deselected
	assign do_o = ~cs_i | ((state == FS_READ) ? dout_q : ~wr.busy);

endmodule

// ==== design/ee_wr_if.sv ====
// Front end to write engine link
`timescale 1ns/1ps
`include "ee_macros.svh"

interface ee_wr_if;
	import ee_types_pkg::*;

	logic wr_start;		// One-cycle job request
	logic wr_all;		// Job covers every address
	logic wr_erase;		// Store the erased value
	ee_addr_t wr_addr;
	ee_word_t wr_data;
	logic wr_enable;	// Write-enable latch level
	ee_addr_t rd_addr;
	logic busy;			// Engine not idle
	ee_word_t rd_data;	// Array word at rd_addr, combinational

	modport front (
		output wr_start, wr_all, wr_erase, wr_addr, wr_data, wr_enable, rd_addr,
		input busy, rd_data
	);

	modport engine (
		input wr_start, wr_all, wr_erase, wr_addr, wr_data, wr_enable, rd_addr,
		output busy, rd_data
	);

endinterface

// ==== design/ee_cmd_pkg.sv ====
// EEPROM instruction and state types
`include "ee_macros.svh"

package ee_cmd_pkg;

	// Full instruction as shifted in, MSB is the start bit
	typedef logic [`EE_IR_W-1:0] ee_ir_t;

	typedef enum logic [1:0] {
		OP_EXT   = 2'b00,	// Sub-op in top address bits
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10,
		OP_ERASE = 2'b11
	} ee_op_e;

	// Top two address bits of an OP_EXT instruction
	typedef enum logic [1:0] {
		EXT_EWDS = 2'b00,
		EXT_WRAL = 2'b01,
		EXT_ERAL = 2'b10,
		EXT_EWEN = 2'b11
	} ee_ext_e;

	typedef enum logic [1:0] {
		FS_IDLE,	// Shifting instruction bits
		FS_DATA,	// Collecting write data
		FS_READ		// Shifting the word out
	} ee_front_state_e;

	typedef enum logic [2:0] {
		WS_IDLE,
		WS_BEGIN,
		WS_WRITE,
		WS_LOOP,
		WS_END
	} ee_wr_state_e;

endpackage

// ==== design/ee_types_pkg.sv ====
// EEPROM data path types
`include "ee_macros.svh"

package ee_types_pkg;

	// One array word
	typedef logic [`EE_WORD_W-1:0] ee_word_t;

	// Array address
	typedef logic [`EE_ADDR_W-1:0] ee_addr_t;

	// Counts the 16 serial data bits, wraps to zero after the last
	typedef logic [3:0] ee_bitcnt_t;

endpackage

// ==== design/ee_macros.svh ====
// Serial EEPROM geometry
`ifndef EE_MACROS_SVH
`define EE_MACROS_SVH

// Data word width in bits
`define EE_WORD_W 16

// Word address width, 64 words
`define EE_ADDR_W 6

// Number of words in the array
`define EE_DEPTH 64

// Start bit, two opcode bits, six address bits
`define EE_IR_W 9

// Value left behind by ERASE and ERAL
`define EE_ERASED {`EE_WORD_W{1'b1}}

`endif
